//--- compile.f
+incdir+verif
design/lbm_pkg.sv
design/lattice_bank.sv
design/cell_scanner.sv
design/population_router.sv
design/step_sequencer.sv
design/lbm_solver.sv
verif/lbm_clock_gen.sv
verif/lbm_tb.sv

//--- verif/lbm_tests.svh
`ifndef LBM_TESTS_SVH
`define LBM_TESTS_SVH

// Idle outputs, run length, ignored restart and the zero-step request
task automatic control_behavior();
    int waited;
    int pulses;
    int busy_lost;
    begin_test("control");
    if (busy !== 1'b0)
        value_error("busy after reset", 0, busy);
    if (done !== 1'b0)
        value_error("done after reset", 0, done);
    barriers = '0;
    barriers[20] = 1'b1;
    fill_random();
    load_lattice();
    step_total = 16'd2;
    start = 1'b1;
    @(negedge clk);
    if (busy !== 1'b1)
        value_error("busy after start", 1, busy);
    // Second request while running, must be ignored
    step_total = 16'd5;
    @(negedge clk);
    start = 1'b0;
    waited = 0;
    while (!done && busy === 1'b1 && waited < 1000)
    begin
        @(negedge clk);
        waited++;
    end
    if (done !== 1'b1)
        plain_error("busy fell or the run timed out without a done pulse");
    if (busy !== 1'b0)
        value_error("busy together with done", 0, busy);
    pulses = 0;
    busy_lost = 0;
    repeat (20)
    begin
        @(negedge clk);
        if (done)
            pulses++;
        if (busy)
            busy_lost++;
    end
    if (pulses != 0)
        value_error("extra done pulses", 0, pulses);
    if (busy_lost != 0)
        plain_error("engine restarted after the run ended");
    model_step();
    model_step();
    check_lattice();
    // Zero steps, done on the next cycle and nothing moves
    step_total = '0;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    if (done !== 1'b1)
        value_error("done after zero-step start", 1, done);
    if (busy !== 1'b0)
        value_error("busy after zero-step start", 0, busy);
    @(negedge clk);
    if (done !== 1'b0)
        value_error("done one cycle later", 0, done);
    check_lattice();
    end_test();
endtask

task automatic load_and_readback();
    begin_test("load_readback");
    fill_random();
    load_lattice();
    check_lattice();
    end_test();
endtask

task automatic free_streaming();
    begin_test("free_streaming");
    barriers = '0;
    fill_random();
    load_lattice();
    run_steps(1);
    model_step();
    check_lattice();
    end_test();
endtask

task automatic single_barrier();
    int c;
    int u;
    logic [data_width-1:0] w;
    logic [data_width-1:0] expected;
    begin_test("single_barrier");
    c = 4 * grid_width + 3;
    barriers = '0;
    barriers[c] = 1'b1;
    for (int d = 0; d < dir_count; d++)
        for (int i = 0; i < cell_count; i++)
            model[d][i] = data_width'(d * 256 + i + 1);
    load_lattice();
    run_steps(1);
    // A population heading into the wall returns reversed to where it started
    for (int d = 1; d < dir_count; d++)
    begin
        u = upstream(c, d);
        expected = data_width'(d * 256 + u + 1);
        read_word(opp_tab[d], u, w);
        if (w !== expected)
            value_error($sformatf("dir %0d cell %0d", opp_tab[d], u), expected, w);
    end
    for (int d = 0; d < dir_count; d++)
    begin
        read_word(d, c, w);
        if (w !== '0)
            value_error($sformatf("barrier dir %0d", d), 0, w);
    end
    model_step();
    check_lattice();
    end_test();
endtask

task automatic walls_and_edges();
    begin_test("walls_and_edges");
    barriers = '0;
    for (int y = 0; y < grid_height; y++)
        barriers[y * grid_width + 5] = 1'b1;
    barriers[0] = 1'b1;
    fill_random();
    load_lattice();
    run_steps(3);
    repeat (3) model_step();
    check_lattice();
    end_test();
endtask

`endif

//--- verif/lbm_tb.sv
`timescale 1ns/1ps

module lbm_tb
    import lbm_pkg::*;
();

    logic                        clk;
    logic                        rst;
    logic                        start;
    logic [step_count_width-1:0] step_total;
    logic [cell_count-1:0]       barriers;
    logic                        busy;
    logic                        done;
    logic [dir_width-1:0]        host_dir;
    logic [addr_width-1:0]       host_addr;
    logic                        host_wr_en;
    logic [data_width-1:0]       host_wr_data;
    logic                        host_rd_en;
    logic [data_width-1:0]       host_rd_data;
    logic                        host_rd_valid;

    // D2Q9 offsets and reversals by direction number
    int dx_tab [dir_count] = '{0, 0, 1, 1, 1, 0, -1, -1, -1};
    int dy_tab [dir_count] = '{0, -1, -1, 0, 1, 1, 1, 0, -1};
    int opp_tab [dir_count] = '{0, 5, 6, 7, 8, 1, 2, 3, 4};

    // Software copy of the current bank
    logic [data_width-1:0] model [dir_count][cell_count];
    logic [31:0] rng_state = 32'hf351_f350;
    string test_name;
    int test_errors;
    int tests_passed;
    int tests_failed;

    lbm_clock_gen i_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    lbm_solver i_dut (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .step_total    (step_total),
        .barriers      (barriers),
        .busy          (busy),
        .done          (done),
        .host_dir      (host_dir),
        .host_addr     (host_addr),
        .host_wr_en    (host_wr_en),
        .host_wr_data  (host_wr_data),
        .host_rd_en    (host_rd_en),
        .host_rd_data  (host_rd_data),
        .host_rd_valid (host_rd_valid)
    );

    //////////////////////////////////////////////////////////////////////
    // Random words and the reference lattice
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [data_width-1:0] random_word();
        rng_state = xorshift32(rng_state);
        return rng_state[data_width-1:0];
    endfunction

    // Source cell of direction d or -1 off the grid
    function automatic int upstream(input int c, input int d);
        int sx;
        int sy;
        sx = c % grid_width - dx_tab[d];
        sy = c / grid_width - dy_tab[d];
        if (sx < 0 || sx >= grid_width || sy < 0 || sy >= grid_height)
            return -1;
        return sy * grid_width + sx;
    endfunction

    task automatic model_step();
        logic [data_width-1:0] nxt [dir_count][cell_count];
        int s;
        for (int c = 0; c < cell_count; c++)
        begin
            for (int d = 0; d < dir_count; d++)
            begin
                s = upstream(c, d);
                nxt[d][c] = (s < 0) ? '0 : model[d][s];
            end
        end
        // Arrivals at a wall go back reversed, unless the source is a wall too
        for (int c = 0; c < cell_count; c++)
        begin
            for (int d = 1; d < dir_count; d++)
            begin
                s = upstream(c, d);
                if (barriers[c] && s >= 0 && !barriers[s])
                    nxt[opp_tab[d]][s] = nxt[d][c];
            end
        end
        for (int c = 0; c < cell_count; c++)
            for (int d = 0; d < dir_count; d++)
                if (barriers[c])
                    nxt[d][c] = '0;
        model = nxt;
    endtask

    task automatic fill_random();
        for (int d = 0; d < dir_count; d++)
            for (int c = 0; c < cell_count; c++)
                model[d][c] = random_word();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reporting
    //////////////////////////////////////////////////////////////////////

    task automatic begin_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0)
        begin
            tests_passed++;
            $display("Test %s passed", test_name);
        end
        else
        begin
            tests_failed++;
            $display("Test %s failed with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic value_error(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        $display("Error %s, %s: expected 0x%0h, actual 0x%0h", test_name, what, expected, actual);
        test_errors++;
    endtask

    task automatic plain_error(input string what);
        $display("Test %s: %s", test_name, what);
        test_errors++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Host port and run control driven from the falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic write_word(input int d, input int c, input logic [data_width-1:0] w);
        host_dir = dir_width'(d);
        host_addr = addr_width'(c);
        host_wr_data = w;
        host_wr_en = 1'b1;
        @(negedge clk);
        host_wr_en = 1'b0;
    endtask

    task automatic read_word(input int d, input int c, output logic [data_width-1:0] w);
        int waited;
        host_dir = dir_width'(d);
        host_addr = addr_width'(c);
        host_rd_en = 1'b1;
        waited = 0;
        do
        begin
            @(negedge clk);
            host_rd_en = 1'b0;
            waited++;
        end
        while (!host_rd_valid && waited < 20);
        if (!host_rd_valid)
            plain_error("host_rd_valid never rose after a read request");
        else if (waited != 1)
            plain_error($sformatf("host_rd_valid rose %0d cycles after the request", waited));
        w = host_rd_data;
        // Valid is a single pulse, so the next request starts from low
        @(negedge clk);
        if (host_rd_valid !== 1'b0)
            plain_error("host_rd_valid stayed high after the read completed");
    endtask

    task automatic load_lattice();
        for (int d = 0; d < dir_count; d++)
            for (int c = 0; c < cell_count; c++)
                write_word(d, c, model[d][c]);
    endtask

    task automatic check_lattice();
        logic [data_width-1:0] w;
        for (int d = 0; d < dir_count; d++)
        begin
            for (int c = 0; c < cell_count; c++)
            begin
                read_word(d, c, w);
                if (w !== model[d][c])
                    value_error($sformatf("dir %0d cell %0d", d, c), model[d][c], w);
            end
        end
    endtask

    task automatic run_steps(input int n);
        int waited;
        step_total = step_count_width'(n);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        waited = 0;
        while (!done && waited < 400 * n + 20)
        begin
            @(negedge clk);
            waited++;
        end
        if (!done)
            plain_error("done did not arrive before the timeout");
    endtask

    `include "lbm_tests.svh"

    initial
    begin
        int waited;
        start = 1'b0;
        step_total = '0;
        barriers = '0;
        host_dir = '0;
        host_addr = '0;
        host_wr_en = 1'b0;
        host_wr_data = '0;
        host_rd_en = 1'b0;
        tests_passed = 0;
        tests_failed = 0;
        waited = 0;
        while (rst !== 1'b0 && waited < 50)
        begin
            @(negedge clk);
            waited++;
        end
        if (rst !== 1'b0)
        begin
            $display("Reset was never released");
            tests_failed++;
        end
        control_behavior();
        load_and_readback();
        free_streaming();
        single_barrier();
        walls_and_edges();
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

//--- verif/lbm_clock_gen.sv
`timescale 1ns/1ps

module lbm_clock_gen
(
    output logic clk,
    output logic rst
);

    // 20 ns period
    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset spans the first five rising edges
    initial
    begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- design/lbm_solver.sv
`timescale 1ns/1ps

module lbm_solver
    import lbm_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  logic [step_count_width-1:0] step_total,
    input  logic [cell_count-1:0]       barriers,
    output logic                        busy,
    output logic                        done,
    input  logic [dir_width-1:0]        host_dir,
    input  logic [addr_width-1:0]       host_addr,
    input  logic                        host_wr_en,
    input  logic [data_width-1:0]       host_wr_data,
    input  logic                        host_rd_en,
    output logic [data_width-1:0]       host_rd_data,
    output logic                        host_rd_valid
);

    // Scanner outputs
    logic [addr_width-1:0] cell_addr;
    logic                  cell_barrier;
    logic [addr_width-1:0] nbr_addr [dir_count];
    logic [dir_count-1:0]  nbr_valid;
    logic [dir_count-1:0]  nbr_fluid;
    logic                  scan_last;

    // Sequencer controls
    logic       scan_start;
    logic       scan_step;
    logic [1:0] phase;
    logic       issue;
    logic       swap;

    // Engine side of the planes
    logic [addr_width-1:0] rd_addr [dir_count];
    logic                  rd_bank_next;
    logic [data_width-1:0] rd_data [dir_count];
    logic [dir_count-1:0]  wr_en;
    logic [addr_width-1:0] wr_addr [dir_count];
    logic [data_width-1:0] wr_data [dir_count];

    step_sequencer i_step_sequencer (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .step_total   (step_total),
        .cell_barrier (cell_barrier),
        .scan_last    (scan_last),
        .scan_start   (scan_start),
        .scan_step    (scan_step),
        .phase        (phase),
        .issue        (issue),
        .swap         (swap),
        .busy         (busy),
        .done         (done)
    );

    cell_scanner i_cell_scanner (
        .clk          (clk),
        .rst          (rst),
        .barriers     (barriers),
        .scan_start   (scan_start),
        .scan_step    (scan_step),
        .cell_addr    (cell_addr),
        .cell_barrier (cell_barrier),
        .nbr_addr     (nbr_addr),
        .nbr_valid    (nbr_valid),
        .nbr_fluid    (nbr_fluid),
        .scan_last    (scan_last)
    );

    population_router i_population_router (
        .clk          (clk),
        .rst          (rst),
        .phase        (phase),
        .issue        (issue),
        .cell_addr    (cell_addr),
        .cell_barrier (cell_barrier),
        .nbr_addr     (nbr_addr),
        .nbr_valid    (nbr_valid),
        .nbr_fluid    (nbr_fluid),
        .rd_addr      (rd_addr),
        .rd_bank_next (rd_bank_next),
        .rd_data      (rd_data),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data)
    );

    lattice_bank i_lattice_bank (
        .clk           (clk),
        .rst           (rst),
        .busy          (busy),
        .swap          (swap),
        .rd_bank_next  (rd_bank_next),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .host_dir      (host_dir),
        .host_addr     (host_addr),
        .host_wr_en    (host_wr_en),
        .host_wr_data  (host_wr_data),
        .host_rd_en    (host_rd_en),
        .host_rd_data  (host_rd_data),
        .host_rd_valid (host_rd_valid)
    );

endmodule

//--- design/step_sequencer.sv
`timescale 1ns/1ps

module step_sequencer
    import lbm_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  logic [step_count_width-1:0] step_total,
    input  logic                        cell_barrier,
    input  logic                        scan_last,
    output logic                        scan_start,
    output logic                        scan_step,
    output logic [1:0]                  phase,
    output logic                        issue,
    output logic                        swap,
    output logic                        busy,
    output logic                        done
);

    logic [2:0] state;
    logic [step_count_width-1:0] step_target;
    logic [step_count_width-1:0] steps_done;
    logic scanning;

    //////////////////////////////////////////////////////////////////////
    // Scan and issue control
    //////////////////////////////////////////////////////////////////////

    assign scanning = (state == st_stream) || (state == st_bounce) || (state == st_zero);
    assign busy = (state != st_idle);

    // Scanner sits on cell 0 whenever no phase is running
    assign scan_start = !scanning;
    assign scan_step = scanning && !scan_last;

    // Bounce and zero only touch barrier cells
    assign issue = (state == st_stream) || (scanning && cell_barrier);
    assign swap = (state == st_swap);

    //////////////////////////////////////////////////////////////////////
    // Phase FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= st_idle;
            phase <= phase_stream;
            step_target <= '0;
            steps_done <= '0;
            done <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                st_idle:
                begin
                    if (start)
                    begin
                        if (step_total == '0)
                            done <= 1'b1;
                        else
                        begin
                            step_target <= step_total;
                            steps_done <= '0;
                            phase <= phase_stream;
                            state <= st_stream;
                        end
                    end
                end
                st_stream, st_bounce, st_zero:
                begin
                    if (scan_last)
                        state <= st_drain;
                end
                st_drain:
                begin
                    // Final write of the phase lands here
                    case (phase)
                        phase_stream:
                        begin
                            phase <= phase_bounce;
                            state <= st_bounce;
                        end
                        phase_bounce:
                        begin
                            phase <= phase_zero;
                            state <= st_zero;
                        end
                        default:
                            state <= st_swap;
                    endcase
                end
                st_swap:
                begin
                    if (step_count_width'(steps_done + 1'b1) == step_target)
                    begin
                        state <= st_idle;
                        done <= 1'b1;
                    end
                    else
                    begin
                        steps_done <= steps_done + 1'b1;
                        phase <= phase_stream;
                        state <= st_stream;
                    end
                end
                default:
                    state <= st_idle;
            endcase
        end
    end

    // A new run is never accepted on the cycle of a done pulse
    a_no_start_on_done: assert property (
        @(posedge clk) disable iff (rst) (start && !busy) |-> !done);

endmodule

//--- design/population_router.sv
`timescale 1ns/1ps

module population_router
    import lbm_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [1:0]            phase,
    input  logic                  issue,
    input  logic [addr_width-1:0] cell_addr,
    input  logic                  cell_barrier,
    input  logic [addr_width-1:0] nbr_addr [dir_count],
    input  logic [dir_count-1:0]  nbr_valid,
    input  logic [dir_count-1:0]  nbr_fluid,
    output logic [addr_width-1:0] rd_addr [dir_count],
    output logic                  rd_bank_next,
    input  logic [data_width-1:0] rd_data [dir_count],
    output logic [dir_count-1:0]  wr_en,
    output logic [addr_width-1:0] wr_addr [dir_count],
    output logic [data_width-1:0] wr_data [dir_count]
);

    // Write plan for the cell whose read data arrives next cycle
    logic                  p_valid;
    logic [1:0]            p_phase;
    logic [addr_width-1:0] p_cell_addr;
    logic [addr_width-1:0] p_nbr_addr [dir_count];
    logic [dir_count-1:0]  p_nbr_valid;
    logic [dir_count-1:0]  p_nbr_fluid;

    // Stream pulls from upstream in the current bank, bounce reads the cell itself
    always_comb
    begin
        for (int d = 0; d < dir_count; d++)
            rd_addr[d] = (phase == phase_stream) ? nbr_addr[d] : cell_addr;
    end

    assign rd_bank_next = (phase == phase_bounce);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            p_valid <= 1'b0;
        else
            p_valid <= issue && ((phase == phase_stream) || cell_barrier);
    end

    always_ff @(posedge clk)
    begin
        p_phase <= phase;
        p_cell_addr <= cell_addr;
        p_nbr_addr <= nbr_addr;
        p_nbr_valid <= nbr_valid;
        p_nbr_fluid <= nbr_fluid;
    end

    always_comb
    begin
        wr_en = '0;
        for (int d = 0; d < dir_count; d++)
        begin
            wr_addr[d] = p_cell_addr;
            wr_data[d] = '0;
        end
        if (p_valid)
        begin
            case (p_phase)
                phase_stream:
                begin
                    // Zero inflow across the grid edge
                    wr_en = '1;
                    for (int d = 0; d < dir_count; d++)
                        wr_data[d] = p_nbr_valid[d] ? rd_data[d] : '0;
                end
                phase_bounce:
                begin
                    // Send each arrival back where it came from, reversed
                    for (int d = 1; d < dir_count; d++)
                    begin
                        wr_en[opposite_dir(d)] = p_nbr_fluid[d];
                        wr_addr[opposite_dir(d)] = p_nbr_addr[d];
                        wr_data[opposite_dir(d)] = rd_data[d];
                    end
                end
                default:
                    wr_en = '1;
            endcase
        end
    end

endmodule

//--- design/cell_scanner.sv
`timescale 1ns/1ps

module cell_scanner
    import lbm_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [cell_count-1:0]  barriers,
    input  logic                   scan_start,
    input  logic                   scan_step,
    output logic [addr_width-1:0]  cell_addr,
    output logic                   cell_barrier,
    output logic [addr_width-1:0]  nbr_addr [dir_count],
    output logic [dir_count-1:0]   nbr_valid,
    output logic [dir_count-1:0]   nbr_fluid,
    output logic                   scan_last
);

    logic [coord_width-1:0] x;
    logic [coord_width-1:0] y;

    // Row-major cell index straight from the counters
    assign cell_addr = {y, x};
    assign cell_barrier = barriers[cell_addr];
    assign scan_last = (x == grid_width - 1) && (y == grid_height - 1);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            x <= '0;
            y <= '0;
        end
        else if (scan_start)
        begin
            x <= '0;
            y <= '0;
        end
        else if (scan_step)
        begin
            if (x == grid_width - 1)
            begin
                x <= '0;
                y <= y + 1'b1;
            end
            else
                x <= x + 1'b1;
        end
    end

    // Upstream cell per direction is the cell minus its unit vector
    always_comb
    begin
        int sx;
        int sy;
        for (int d = 0; d < dir_count; d++)
        begin
            sx = int'(x) - dir_dx(d);
            sy = int'(y) - dir_dy(d);
            nbr_valid[d] = (sx >= 0) && (sx < grid_width) && (sy >= 0) && (sy < grid_height);
            nbr_addr[d] = addr_width'(sy * grid_width + sx);
            nbr_fluid[d] = nbr_valid[d] && !barriers[nbr_addr[d]];
        end
    end

    a_no_step_past_end: assert property (
        @(posedge clk) disable iff (rst) scan_last |-> !scan_step);

endmodule

//--- design/lattice_bank.sv
`timescale 1ns/1ps

module lattice_bank
    import lbm_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  busy,
    input  logic                  swap,
    input  logic                  rd_bank_next,
    input  logic [addr_width-1:0] rd_addr [dir_count],
    output logic [data_width-1:0] rd_data [dir_count],
    input  logic [dir_count-1:0]  wr_en,
    input  logic [addr_width-1:0] wr_addr [dir_count],
    input  logic [data_width-1:0] wr_data [dir_count],
    input  logic [dir_width-1:0]  host_dir,
    input  logic [addr_width-1:0] host_addr,
    input  logic                  host_wr_en,
    input  logic [data_width-1:0] host_wr_data,
    input  logic                  host_rd_en,
    output logic [data_width-1:0] host_rd_data,
    output logic                  host_rd_valid
);

    // High when bank 1 holds the current time step
    logic bank_sel;
    logic [data_width-1:0] host_word [dir_count];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            bank_sel <= 1'b0;
        else if (swap)
            bank_sel <= ~bank_sel;
    end

    //////////////////////////////////////////////////////////////////////
    // One plane per direction, both banks in one array
    //////////////////////////////////////////////////////////////////////

    for (genvar d = 0; d < dir_count; d++)
    begin : g_plane
        logic [data_width-1:0] mem [2*cell_count];
        logic host_hit;

        assign host_hit = host_wr_en && (host_dir == d);

        always_ff @(posedge clk)
        begin
            // Engine writes land in the next bank, host writes in the current one
            if (wr_en[d])
                mem[{~bank_sel, wr_addr[d]}] <= wr_data[d];
            else if (host_hit)
                mem[{bank_sel, host_addr}] <= host_wr_data;
            rd_data[d] <= mem[{rd_bank_next ^ bank_sel, rd_addr[d]}];
        end

        assign host_word[d] = mem[{bank_sel, host_addr}];
    end

    //////////////////////////////////////////////////////////////////////
    // Host read port, one cycle latency
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            host_rd_valid <= 1'b0;
        else
            host_rd_valid <= host_rd_en;
    end

    always_ff @(posedge clk)
    begin
        if (host_rd_en)
            host_rd_data <= host_word[host_dir];
    end

    // The host owns the planes only while the engine is idle
    a_no_host_while_busy: assert property (
        @(posedge clk) disable iff (rst) busy |-> !(host_wr_en || host_rd_en));

    // Last engine write must land before the banks change roles
    a_no_write_on_swap: assert property (
        @(posedge clk) disable iff (rst) swap |-> (wr_en == '0));

endmodule

//--- design/lbm_pkg.sv
package lbm_pkg;

    // Grid geometry
    localparam int grid_width = 8;
    localparam int grid_height = 8;
    localparam int cell_count = grid_width * grid_height;
    localparam int coord_width = 3;
    localparam int addr_width = 6;

    // Word widths
    localparam int data_width = 16;
    localparam int dir_count = 9;
    localparam int dir_width = 4;
    localparam int step_count_width = 16;

    // D2Q9 numbering, north is row minus one and east is column plus one
    localparam logic [dir_width-1:0] dir_rest = 4'd0;
    localparam logic [dir_width-1:0] dir_n = 4'd1;
    localparam logic [dir_width-1:0] dir_ne = 4'd2;
    localparam logic [dir_width-1:0] dir_e = 4'd3;
    localparam logic [dir_width-1:0] dir_se = 4'd4;
    localparam logic [dir_width-1:0] dir_s = 4'd5;
    localparam logic [dir_width-1:0] dir_sw = 4'd6;
    localparam logic [dir_width-1:0] dir_w = 4'd7;
    localparam logic [dir_width-1:0] dir_nw = 4'd8;

    // Engine phases
    localparam logic [1:0] phase_stream = 2'd0;
    localparam logic [1:0] phase_bounce = 2'd1;
    localparam logic [1:0] phase_zero = 2'd2;

    // Sequencer states
    localparam logic [2:0] st_idle = 3'd0;
    localparam logic [2:0] st_stream = 3'd1;
    localparam logic [2:0] st_bounce = 3'd2;
    localparam logic [2:0] st_zero = 3'd3;
    localparam logic [2:0] st_drain = 3'd4;
    localparam logic [2:0] st_swap = 3'd5;

    // Moving directions sit in a ring of eight, so reversal is a shift by four
    function automatic int opposite_dir(input int d);
        if (d == dir_rest)
            return dir_rest;
        return ((d + 3) % 8) + 1;
    endfunction

    function automatic int dir_dx(input int d);
        case (d)
            dir_ne, dir_e, dir_se: return 1;
            dir_sw, dir_w, dir_nw: return -1;
            default: return 0;
        endcase
    endfunction

    function automatic int dir_dy(input int d);
        case (d)
            dir_n, dir_ne, dir_nw: return -1;
            dir_se, dir_s, dir_sw: return 1;
            default: return 0;
        endcase
    endfunction

endpackage
